// ==== design/mcsr_settings.svh ====
`ifndef MCSR_SETTINGS_SVH
`define MCSR_SETTINGS_SVH

//////////////////////////////////////////////////
// Core width
//////////////////////////////////////////////////

`define XLEN 32

// Fixed trap vector, direct mode only
`define MTVEC_BASE 32'h0000_0100

//////////////////////////////////////////////////
// Machine timer word offsets
//////////////////////////////////////////////////

`define TMR_MTIME_LO    2'd0   // mtime[31:0]
`define TMR_MTIME_HI    2'd1   // mtime[63:32]
`define TMR_MTIMECMP_LO 2'd2   // mtimecmp[31:0]
`define TMR_MTIMECMP_HI 2'd3   // mtimecmp[63:32]

// Compare value out of reset
// All ones keeps the timer quiet until software programs it
`define MTIMECMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif

// ==== design/mcsr_pkg.sv ====
`default_nettype none

`include "mcsr_settings.svh"

package mcsr_pkg;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  // CSR instruction flavour
  typedef enum logic [1:0] {
    CSR_NOP = 2'd0,  // No access this cycle
    CSR_RW  = 2'd1,  // Swap
    CSR_RS  = 2'd2,  // Set bits
    CSR_RC  = 2'd3   // Clear bits
  } csr_op_e;

  // Implemented machine CSR numbers
  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MTVAL    = 12'h343,
    CSR_MIP      = 12'h344
  } csr_addr_e;

  // Interrupt flag set, timer interrupt code 7
  localparam logic [`XLEN-1:0] CAUSE_M_TIMER = 32'h8000_0007;

  //////////////////////////////////////////////////
  // CSR field layouts
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [18:0] rsvd_31_13;
    logic [1:0]  mpp;         // Machine only, reads 2'b11
    logic [2:0]  rsvd_10_8;
    logic        mpie;        // Saved mie
    logic [2:0]  rsvd_6_4;
    logic        mie;         // Global enable
    logic [2:0]  rsvd_2_0;
  } mstatus_t;

  typedef struct packed {
    logic [23:0] rsvd_31_8;
    logic        mtie;        // Timer enable
    logic [6:0]  rsvd_6_0;
  } mie_t;

  typedef struct packed {
    logic [23:0] rsvd_31_8;
    logic        mtip;        // Timer pending, live from the timer
    logic [6:0]  rsvd_6_0;
  } mip_t;

  //////////////////////////////////////////////////
  // Request and command bundles
  //////////////////////////////////////////////////

  // CSR instruction from the core
  typedef struct packed {
    csr_op_e          op;
    logic [11:0]      addr;   // Raw number, may be unimplemented
    logic [`XLEN-1:0] wdata;
  } csr_req_t;

  // Timer bus access
  typedef struct packed {
    logic             we;
    logic [1:0]       sel;    // Word offset
    logic [`XLEN-1:0] wdata;
  } tmr_req_t;

  // Exception from the pipeline controller
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;     // Also the resume pc for interrupts
    logic [`XLEN-1:0] cause;
    logic [`XLEN-1:0] tval;
  } exc_req_t;

  // Trap unit to CSR file
  typedef struct packed {
    logic             take;   // Commit trap state
    logic             mret;   // Restore from trap
    logic [`XLEN-1:0] epc;
    logic [`XLEN-1:0] cause;
    logic [`XLEN-1:0] tval;
  } trap_cmd_t;

endpackage

`default_nettype wire

// ==== design/csr_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcsr_settings.svh"

module csr_regfile (
  input  logic                clk,
  input  logic                rst,
  input  mcsr_pkg::csr_req_t  csr_req_i,
  input  mcsr_pkg::trap_cmd_t trap_cmd_i,
  input  logic                tmr_expired_i,
  output logic [`XLEN-1:0]    csr_rdata_o,
  output logic                csr_illegal_o,
  output logic                irq_en_o,
  output logic [`XLEN-1:0]    mepc_o
);
  import mcsr_pkg::*;

  // Stored bits only, the rest is hardwired
  logic             st_mie_q;     // mstatus.mie
  logic             st_mpie_q;    // mstatus.mpie
  logic             mtie_q;       // mie.mtie
  logic [`XLEN-1:0] mscratch_q;
  logic [`XLEN-1:0] mepc_q;
  logic [`XLEN-1:0] mcause_q;
  logic [`XLEN-1:0] mtval_q;

  mstatus_t         status_rd;
  mstatus_t         status_wr;
  mie_t             mie_rd;
  mie_t             mie_wr;
  mip_t             mip_rd;
  logic             addr_hit;
  logic             wr_en;
  logic [`XLEN-1:0] rd_val;
  logic [`XLEN-1:0] wr_val;

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    status_rd      = '0;
    status_rd.mpp  = 2'b11;       // M-mode only
    status_rd.mpie = st_mpie_q;
    status_rd.mie  = st_mie_q;
    mie_rd         = '0;
    mie_rd.mtie    = mtie_q;
    mip_rd         = '0;
    mip_rd.mtip    = tmr_expired_i; // Level from timer, not stored

    addr_hit = 1'b1;
    case (csr_req_i.addr)
      CSR_MSTATUS:  rd_val = status_rd;
      CSR_MIE:      rd_val = mie_rd;
      CSR_MTVEC:    rd_val = `MTVEC_BASE;
      CSR_MSCRATCH: rd_val = mscratch_q;
      CSR_MEPC:     rd_val = mepc_q;
      CSR_MCAUSE:   rd_val = mcause_q;
      CSR_MTVAL:    rd_val = mtval_q;
      CSR_MIP:      rd_val = mip_rd;
      default: begin
        rd_val   = '0;                // Unimplemented reads 0
        addr_hit = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Op decode
  //////////////////////////////////////////////////

  always_comb begin
    case (csr_req_i.op)
      CSR_RW:  wr_val = csr_req_i.wdata;
      CSR_RS:  wr_val = rd_val | csr_req_i.wdata;
      CSR_RC:  wr_val = rd_val & ~csr_req_i.wdata;
      default: wr_val = rd_val;      // NOP leaves old value
    endcase
  end

  assign wr_en         = (csr_req_i.op != CSR_NOP) && addr_hit;
  assign csr_illegal_o = (csr_req_i.op != CSR_NOP) && !addr_hit;
  assign status_wr     = mstatus_t'(wr_val);  // Field view of write value
  assign mie_wr        = mie_t'(wr_val);

  assign csr_rdata_o = rd_val;      // Old value out
  assign irq_en_o    = st_mie_q & mtie_q;
  assign mepc_o      = mepc_q;

  //////////////////////////////////////////////////
  // Register update
  //////////////////////////////////////////////////

  // Later assignments win, so trap and mret override a CSR write
  always_ff @(posedge clk) begin
    if (rst) begin
      st_mie_q   <= 1'b0;
      st_mpie_q  <= 1'b0;
      mtie_q     <= 1'b0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      if (wr_en) begin
        case (csr_req_i.addr)
          CSR_MSTATUS: begin
            st_mie_q  <= status_wr.mie;
            st_mpie_q <= status_wr.mpie;
          end
          CSR_MIE:      mtie_q     <= mie_wr.mtie;
          CSR_MSCRATCH: mscratch_q <= wr_val;
          CSR_MEPC:     mepc_q     <= {wr_val[`XLEN-1:2], 2'b00}; // IALIGN 32
          CSR_MCAUSE:   mcause_q   <= wr_val;
          CSR_MTVAL:    mtval_q    <= wr_val;
          default: ;                 // mtvec and mip are read-only
        endcase
      end

      if (trap_cmd_i.take) begin
        mepc_q    <= trap_cmd_i.epc;
        mcause_q  <= trap_cmd_i.cause;
        mtval_q   <= trap_cmd_i.tval;
        st_mpie_q <= st_mie_q;      // Stack the enable
        st_mie_q  <= 1'b0;          // Handler runs masked
      end else if (trap_cmd_i.mret) begin
        st_mie_q  <= st_mpie_q;     // Pop the enable
        st_mpie_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/machine_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcsr_settings.svh"

module machine_timer (
  input  logic               clk,
  input  logic               rst,
  input  mcsr_pkg::tmr_req_t tmr_req_i,
  output logic [`XLEN-1:0]   tmr_rdata_o,
  output logic               tmr_expired_o
);
  import mcsr_pkg::*;

  logic [2*`XLEN-1:0] mtime_q;
  logic [2*`XLEN-1:0] mtimecmp_q;
  logic               wr_mtime_lo;
  logic               wr_mtime_hi;
  logic               wr_cmp_lo;
  logic               wr_cmp_hi;

  // Half-word write strobes
  assign wr_mtime_lo = tmr_req_i.we && (tmr_req_i.sel == `TMR_MTIME_LO);
  assign wr_mtime_hi = tmr_req_i.we && (tmr_req_i.sel == `TMR_MTIME_HI);
  assign wr_cmp_lo   = tmr_req_i.we && (tmr_req_i.sel == `TMR_MTIMECMP_LO);
  assign wr_cmp_hi   = tmr_req_i.we && (tmr_req_i.sel == `TMR_MTIMECMP_HI);

  //////////////////////////////////////////////////
  // Counter and compare registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= `MTIMECMP_RESET;
    end else begin
      // Written half is loaded as is, no increment that cycle
      if (wr_mtime_lo) begin
        mtime_q <= {mtime_q[2*`XLEN-1:`XLEN], tmr_req_i.wdata};
      end else if (wr_mtime_hi) begin
        mtime_q <= {tmr_req_i.wdata, mtime_q[`XLEN-1:0]};
      end else begin
        mtime_q <= mtime_q + 1'b1;  // Free running, carry into upper half
      end

      if (wr_cmp_lo) begin
        mtimecmp_q[`XLEN-1:0] <= tmr_req_i.wdata;
      end
      if (wr_cmp_hi) begin
        mtimecmp_q[2*`XLEN-1:`XLEN] <= tmr_req_i.wdata;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read port and expiry
  //////////////////////////////////////////////////

  always_comb begin
    case (tmr_req_i.sel)
      `TMR_MTIME_LO:    tmr_rdata_o = mtime_q[`XLEN-1:0];
      `TMR_MTIME_HI:    tmr_rdata_o = mtime_q[2*`XLEN-1:`XLEN];
      `TMR_MTIMECMP_LO: tmr_rdata_o = mtimecmp_q[`XLEN-1:0];
      default:          tmr_rdata_o = mtimecmp_q[2*`XLEN-1:`XLEN];
    endcase
  end

  // Unsigned 64-bit compare on registered values
  // Stays high until mtimecmp moves past mtime
  assign tmr_expired_o = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// ==== design/trap_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcsr_settings.svh"

module trap_unit (
  input  mcsr_pkg::exc_req_t  exc_req_i,
  input  logic                mret_i,
  input  logic                tmr_expired_i,
  input  logic                irq_en_i,
  input  logic [`XLEN-1:0]    mepc_i,
  output mcsr_pkg::trap_cmd_t trap_cmd_o,
  output logic                redirect_o,
  output logic [`XLEN-1:0]    redirect_pc_o
);
  import mcsr_pkg::*;

  logic take_exc;
  logic take_irq;
  logic take;
  logic do_mret;

  //////////////////////////////////////////////////
  // Priority: exception, interrupt, mret
  //////////////////////////////////////////////////

  // Synchronous exceptions ignore mstatus.mie
  assign take_exc = exc_req_i.valid;

  // Timer only when enabled and nothing synchronous pending
  assign take_irq = !take_exc && tmr_expired_i && irq_en_i;

  assign take    = take_exc | take_irq;
  assign do_mret = mret_i && !take;   // Trap wins over mret

  //////////////////////////////////////////////////
  // Trap command
  //////////////////////////////////////////////////

  always_comb begin
    trap_cmd_o      = '0;
    trap_cmd_o.take = take;
    trap_cmd_o.mret = do_mret;
    if (take_exc) begin
      // Faulting pc, word aligned
      trap_cmd_o.epc   = {exc_req_i.pc[`XLEN-1:2], 2'b00};
      trap_cmd_o.cause = exc_req_i.cause;
      trap_cmd_o.tval  = exc_req_i.tval;
    end else if (take_irq) begin
      trap_cmd_o.epc   = exc_req_i.pc;   // Next pc to execute
      trap_cmd_o.cause = CAUSE_M_TIMER;
      trap_cmd_o.tval  = '0;             // No extra info for interrupts
    end
  end

  //////////////////////////////////////////////////
  // Fetch redirect
  //////////////////////////////////////////////////

  assign redirect_o    = take | do_mret;
  assign redirect_pc_o = take ? `MTVEC_BASE : mepc_i;  // Direct mode vector

endmodule

`default_nettype wire

// ==== design/mcsr_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcsr_settings.svh"

module mcsr_top (
  input  logic               clk,
  input  logic               rst,
  // Core side
  input  mcsr_pkg::csr_req_t csr_req_i,
  input  mcsr_pkg::tmr_req_t tmr_req_i,
  output logic [`XLEN-1:0]   csr_rdata_o,
  output logic               csr_illegal_o,
  output logic [`XLEN-1:0]   tmr_rdata_o,
  // Controller side
  input  mcsr_pkg::exc_req_t exc_req_i,
  input  logic               mret_i,
  // Fetch side
  output logic               redirect_o,
  output logic [`XLEN-1:0]   redirect_pc_o
);
  import mcsr_pkg::*;

  logic             tmr_expired;  // Timer level
  logic             irq_en;       // Global and timer enable
  logic [`XLEN-1:0] mepc;
  trap_cmd_t        trap_cmd;

  //////////////////////////////////////////////////
  // Submodules
  //////////////////////////////////////////////////

  csr_regfile u_csr_regfile (
    .clk           (clk),
    .rst           (rst),
    .csr_req_i     (csr_req_i),
    .trap_cmd_i    (trap_cmd),
    .tmr_expired_i (tmr_expired),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal_o),
    .irq_en_o      (irq_en),
    .mepc_o        (mepc)
  );

  machine_timer u_machine_timer (
    .clk           (clk),
    .rst           (rst),
    .tmr_req_i     (tmr_req_i),
    .tmr_rdata_o   (tmr_rdata_o),
    .tmr_expired_o (tmr_expired)
  );

  // Combinational, commits land in the regfile next clk
  trap_unit u_trap_unit (
    .exc_req_i     (exc_req_i),
    .mret_i        (mret_i),
    .tmr_expired_i (tmr_expired),
    .irq_en_i      (irq_en),
    .mepc_i        (mepc),
    .trap_cmd_o    (trap_cmd),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

`default_nettype wire

// ==== tb/mcsr_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcsr_settings.svh"

module mcsr_properties (
  input logic               clk,
  input logic               rst,
  input mcsr_pkg::csr_req_t csr_req_i,
  input mcsr_pkg::exc_req_t exc_req_i,
  input logic               csr_illegal_i,
  input logic               redirect_i,
  input logic [`XLEN-1:0]   redirect_pc_i
);
  import mcsr_pkg::*;

  int unsigned assert_fail_count = 0;  // Tally of property failures

  // Fetch stays put during reset
  redirect_in_reset: assert property (@(posedge clk) rst |-> !redirect_i)
    else begin
      $error("redirect_o high while rst is high");
      assert_fail_count++;
    end

  // Exceptions always vector to the fixed base
  exc_target: assert property (@(posedge clk)
      (redirect_i && exc_req_i.valid) |-> (redirect_pc_i == `MTVEC_BASE))
    else begin
      $error("exception redirect not at MTVEC_BASE");
      assert_fail_count++;
    end

  // No access, no fault
  illegal_on_nop: assert property (@(posedge clk)
      (csr_req_i.op == CSR_NOP) |-> !csr_illegal_i)
    else begin
      $error("csr_illegal_o high with CSR_NOP");
      assert_fail_count++;
    end

endmodule

bind mcsr_top mcsr_properties u_props (
  .clk           (clk),
  .rst           (rst),
  .csr_req_i     (csr_req_i),
  .exc_req_i     (exc_req_i),
  .csr_illegal_i (csr_illegal_o),
  .redirect_i    (redirect_o),
  .redirect_pc_i (redirect_pc_o)
);

`default_nettype wire

// ==== tb/mcsr_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcsr_settings.svh"

module mcsr_tb;
  import mcsr_pkg::*;

  logic             clk;
  logic             rst;
  csr_req_t         csr_req;
  tmr_req_t         tmr_req;
  exc_req_t         exc_req;
  logic             mret;
  logic [`XLEN-1:0] csr_rdata;
  logic             csr_illegal;
  logic [`XLEN-1:0] tmr_rdata;
  logic             redirect;
  logic [`XLEN-1:0] redirect_pc;

  integer seed = 32'h632c;        // Fixed seed for repeatable operands
  string  cur_test;
  int     test_errs = 0;
  int     err_count = 0;
  int     tests_run = 0;
  int     tests_failed = 0;

  mcsr_top dut (
    .clk           (clk),
    .rst           (rst),
    .csr_req_i     (csr_req),
    .tmr_req_i     (tmr_req),
    .csr_rdata_o   (csr_rdata),
    .csr_illegal_o (csr_illegal),
    .tmr_rdata_o   (tmr_rdata),
    .exc_req_i     (exc_req),
    .mret_i        (mret),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  always #2 clk = ~clk;           // 4 ns period

  //////////////////////////////////////////////////
  // Bookkeeping
  //////////////////////////////////////////////////

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end else begin
      $display("test %s ok", cur_test);
    end
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s: %s expected %h actual %h", cur_test, what, exp, act);
      test_errs++;
      err_count++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", cur_test, msg);
    test_errs++;
    err_count++;
  endtask

  //////////////////////////////////////////////////
  // Bus helpers that start and end on a falling edge
  //////////////////////////////////////////////////

  task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic illegal);
    csr_req.op    = op;
    csr_req.addr  = addr;
    csr_req.wdata = wdata;
    #1;                           // Mid low phase with comb outputs settled
    rdata   = csr_rdata;
    illegal = csr_illegal;
    @(negedge clk);               // Write committed at the rising edge
    csr_req = '0;
  endtask

  task automatic csr_expect(input logic [11:0] addr, input logic [31:0] exp,
                            input string what);
    logic [31:0] rd;
    logic        ill;
    csr_access(CSR_NOP, addr, 32'h0, rd, ill);
    check_eq(what, exp, rd);
  endtask

  task automatic tmr_write(input logic [1:0] sel, input logic [31:0] data);
    tmr_req.we    = 1'b1;
    tmr_req.sel   = sel;
    tmr_req.wdata = data;
    @(negedge clk);
    tmr_req.we    = 1'b0;
  endtask

  task automatic tmr_read(input logic [1:0] sel, output logic [31:0] data);
    tmr_req.we  = 1'b0;
    tmr_req.sel = sel;
    #1;
    data = tmr_rdata;
    @(negedge clk);
  endtask

  // One-cycle exception request with the redirect checked in that cycle
  task automatic raise_exception(input logic [31:0] pc, input logic [31:0] cause,
                                 input logic [31:0] tval, input logic with_mret);
    exc_req.valid = 1'b1;
    exc_req.pc    = pc;
    exc_req.cause = cause;
    exc_req.tval  = tval;
    mret          = with_mret;
    #1;
    check_eq("trap redirect", 32'd1, redirect);
    check_eq("trap target", `MTVEC_BASE, redirect_pc);
    @(negedge clk);
    exc_req.valid = 1'b0;
    mret          = 1'b0;
  endtask

  task automatic return_from_trap(input logic [31:0] exp_pc);
    mret = 1'b1;
    #1;
    check_eq("mret redirect", 32'd1, redirect);
    check_eq("mret target", exp_pc, redirect_pc);
    @(negedge clk);
    mret = 1'b0;
  endtask

  // Bounded poll for a redirect that returns after the commit edge
  task automatic wait_redirect(input int limit, output logic seen,
                               output logic [31:0] pc);
    int cycles;
    seen   = 1'b0;
    pc     = '0;
    cycles = 0;
    while (!seen && cycles < limit) begin
      #1;
      if (redirect) begin
        seen = 1'b1;
        pc   = redirect_pc;
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic csr_access_test();
    logic [31:0] model;
    logic [31:0] opnd;
    logic [31:0] rd;
    logic        ill;
    int unsigned pick;
    csr_op_e     op;
    begin_test("csr_access");
    check_eq("redirect after reset", 32'd0, redirect);
    csr_expect(CSR_MSTATUS, 32'h0000_1800, "mstatus reset");  // mpp only
    csr_expect(CSR_MIE, 32'h0, "mie reset");
    csr_expect(CSR_MTVEC, `MTVEC_BASE, "mtvec reset");
    csr_expect(CSR_MSCRATCH, 32'h0, "mscratch reset");
    csr_expect(CSR_MEPC, 32'h0, "mepc reset");
    csr_expect(CSR_MCAUSE, 32'h0, "mcause reset");
    csr_expect(CSR_MTVAL, 32'h0, "mtval reset");
    csr_expect(CSR_MIP, 32'h0, "mip reset");
    // Random swap, set and clear against a local model
    model = '0;
    for (int i = 0; i < 16; i++) begin
      opnd = $random(seed);
      pick = $unsigned($random(seed)) % 3;
      case (pick)
        0:       op = CSR_RW;
        1:       op = CSR_RS;
        default: op = CSR_RC;
      endcase
      csr_access(op, CSR_MSCRATCH, opnd, rd, ill);
      check_eq("mscratch old value", model, rd);
      case (op)
        CSR_RW:  model = opnd;
        CSR_RS:  model = model | opnd;
        default: model = model & ~opnd;
      endcase
    end
    csr_expect(CSR_MSCRATCH, model, "mscratch final");
    // Field masks
    csr_access(CSR_RW, CSR_MSTATUS, 32'hFFFF_FFFF, rd, ill);
    csr_expect(CSR_MSTATUS, 32'h0000_1888, "mstatus mask");
    csr_access(CSR_RW, CSR_MSTATUS, 32'h0, rd, ill);
    csr_access(CSR_RW, CSR_MIE, 32'hFFFF_FFFF, rd, ill);      // mstatus.mie now clear
    csr_expect(CSR_MIE, 32'h0000_0080, "mie mask");
    csr_access(CSR_RW, CSR_MIE, 32'h0, rd, ill);
    csr_access(CSR_RW, CSR_MTVEC, $random(seed), rd, ill);
    check_eq("mtvec write illegal", 32'd0, ill);
    csr_expect(CSR_MTVEC, `MTVEC_BASE, "mtvec read-only");
    csr_access(CSR_RW, CSR_MEPC, 32'h1234_5677, rd, ill);
    csr_expect(CSR_MEPC, 32'h1234_5674, "mepc alignment");
    // Unimplemented number
    csr_access(CSR_RS, 12'h7C0, 32'hFFFF_FFFF, rd, ill);
    check_eq("unknown read", 32'h0, rd);
    check_eq("unknown illegal", 32'd1, ill);
    csr_access(CSR_NOP, 12'h7C0, 32'h0, rd, ill);
    check_eq("unknown nop illegal", 32'd0, ill);
    end_test();
  endtask

  task automatic timer_test();
    logic [31:0] base;
    logic [31:0] hi;
    logic [31:0] cmp_lo;
    logic [31:0] cmp_hi;
    logic [31:0] rd;
    begin_test("timer");
    base = $random(seed) & 32'h7FFF_FFFF;  // No carry in the short run
    hi   = $random(seed);
    tmr_write(`TMR_MTIME_LO, base);
    tmr_write(`TMR_MTIME_HI, hi);           // Holds low half this cycle
    repeat (5) @(negedge clk);
    tmr_read(`TMR_MTIME_LO, rd);
    check_eq("mtime lo after 5", base + 32'd5, rd);
    tmr_read(`TMR_MTIME_HI, rd);
    check_eq("mtime hi", hi, rd);
    // Compare register readback
    cmp_lo = $random(seed);
    cmp_hi = $random(seed);
    tmr_write(`TMR_MTIMECMP_LO, cmp_lo);
    tmr_write(`TMR_MTIMECMP_HI, cmp_hi);
    tmr_read(`TMR_MTIMECMP_LO, rd);
    check_eq("mtimecmp lo", cmp_lo, rd);
    tmr_read(`TMR_MTIMECMP_HI, rd);
    check_eq("mtimecmp hi", cmp_hi, rd);
    tmr_write(`TMR_MTIMECMP_HI, 32'hFFFF_FFFF);
    tmr_write(`TMR_MTIMECMP_LO, 32'hFFFF_FFFF);
    // Carry from low into high half
    tmr_write(`TMR_MTIME_LO, 32'hFFFF_FFFD);
    tmr_write(`TMR_MTIME_HI, 32'h0000_0005);
    repeat (3) @(negedge clk);
    tmr_read(`TMR_MTIME_HI, rd);
    check_eq("mtime hi after carry", 32'h0000_0006, rd);
    tmr_read(`TMR_MTIME_LO, rd);
    check_eq("mtime lo after carry", 32'h0000_0001, rd);
    end_test();
  endtask

  task automatic exception_test();
    logic [31:0] rd;
    logic        ill;
    begin_test("exception");
    raise_exception(32'h0000_3003, 32'd2, 32'hDEAD_BEEF, 1'b0);  // mie clear
    csr_expect(CSR_MEPC, 32'h0000_3000, "mepc");
    csr_expect(CSR_MCAUSE, 32'd2, "mcause");
    csr_expect(CSR_MTVAL, 32'hDEAD_BEEF, "mtval");
    csr_expect(CSR_MSTATUS, 32'h0000_1800, "mstatus after trap, mie was 0");
    csr_access(CSR_RS, CSR_MSTATUS, 32'h0000_0008, rd, ill);   // mtie still clear
    raise_exception(32'h0000_3104, 32'd5, 32'h0000_0BAD, 1'b0);
    csr_expect(CSR_MSTATUS, 32'h0000_1880, "mstatus after trap, mie was 1");
    end_test();
  endtask

  task automatic timer_irq_test();
    logic [31:0] now_lo;
    logic [31:0] now_hi;
    logic [31:0] rd;
    logic [31:0] pc;
    logic        ill;
    logic        seen;
    begin_test("timer_irq");
    exc_req.pc = 32'h0000_2468;               // Resume pc with valid held low
    tmr_read(`TMR_MTIME_HI, now_hi);
    tmr_read(`TMR_MTIME_LO, now_lo);
    tmr_write(`TMR_MTIMECMP_HI, now_hi);
    tmr_write(`TMR_MTIMECMP_LO, now_lo + 32'd30);
    csr_access(CSR_RW, CSR_MIE, 32'h0000_0080, rd, ill);
    csr_access(CSR_RS, CSR_MSTATUS, 32'h0000_0008, rd, ill);
    wait_redirect(100, seen, pc);
    if (!seen) begin
      report_failure("timer interrupt gave no redirect within 100 cycles");
    end
    check_eq("irq target", `MTVEC_BASE, pc);
    csr_expect(CSR_MCAUSE, 32'h8000_0007, "irq mcause");  // Interrupt bit and code 7
    csr_expect(CSR_MTVAL, 32'h0, "irq mtval");
    csr_expect(CSR_MEPC, 32'h0000_2468, "irq mepc");
    // Still pending but masked by mtie
    csr_access(CSR_RC, CSR_MIE, 32'h0000_0080, rd, ill);
    csr_access(CSR_RS, CSR_MSTATUS, 32'h0000_0008, rd, ill);
    wait_redirect(100, seen, pc);
    if (seen) begin
      report_failure("redirect appeared with mtie clear");
    end
    csr_access(CSR_RW, CSR_MSTATUS, 32'h0, rd, ill);
    tmr_write(`TMR_MTIMECMP_HI, 32'hFFFF_FFFF);
    tmr_write(`TMR_MTIMECMP_LO, 32'hFFFF_FFFF);
    end_test();
  endtask

  task automatic mret_test();
    logic [31:0] rd;
    logic        ill;
    begin_test("mret");
    csr_access(CSR_RW, CSR_MEPC, 32'h0000_4440, rd, ill);
    csr_access(CSR_RW, CSR_MSTATUS, 32'h0000_0008, rd, ill);   // mie 1 and mpie 0
    return_from_trap(32'h0000_4440);
    csr_expect(CSR_MSTATUS, 32'h0000_1880, "mstatus after mret, mpie was 0");
    csr_access(CSR_RW, CSR_MSTATUS, 32'h0000_0080, rd, ill);   // mie 0 and mpie 1
    return_from_trap(32'h0000_4440);
    csr_expect(CSR_MSTATUS, 32'h0000_1888, "mstatus after mret, mpie was 1");
    csr_access(CSR_RW, CSR_MSTATUS, 32'h0, rd, ill);
    end_test();
  endtask

  task automatic priority_test();
    logic [31:0] rd;
    logic        ill;
    begin_test("priority");
    tmr_write(`TMR_MTIMECMP_HI, 32'h0);
    tmr_write(`TMR_MTIMECMP_LO, 32'h0);       // Timer expired from here on
    csr_access(CSR_RW, CSR_MIE, 32'h0000_0080, rd, ill);
    csr_access(CSR_RS, CSR_MSTATUS, 32'h0000_0008, rd, ill);
    raise_exception(32'h0000_5554, 32'd11, 32'h0000_0077, 1'b0);  // Same cycle as irq
    csr_expect(CSR_MCAUSE, 32'd11, "exception over irq mcause");
    csr_expect(CSR_MEPC, 32'h0000_5554, "exception over irq mepc");
    // mret along with a trap where mret alone would set mie again
    raise_exception(32'h0000_6668, 32'd3, 32'h0, 1'b1);
    csr_expect(CSR_MCAUSE, 32'd3, "trap over mret mcause");
    csr_expect(CSR_MSTATUS, 32'h0000_1800, "trap over mret mstatus");
    end_test();
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    csr_req = '0;
    tmr_req = '0;
    exc_req = '0;
    mret    = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    csr_access_test();
    timer_test();
    exception_test();
    timer_irq_test();
    mret_test();
    priority_test();

    err_count = err_count + dut.u_props.assert_fail_count;
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_count, dut.u_props.assert_fail_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mcsr_top.f ====
+incdir+design
design/mcsr_pkg.sv
design/csr_regfile.sv
design/machine_timer.sv
design/trap_unit.sv
design/mcsr_top.sv
tb/mcsr_properties.sv
tb/mcsr_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f mcsr_top.f \
  --top-module mcsr_tb -Mdir obj_dir \
  && ./obj_dir/Vmcsr_tb > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^=== PASS ===$" sim.log && echo "simulation passed" && exit 0 \
  || echo "simulation failed" && exit 1
